/* hdl/rv_isa_pkg.sv */
package rv_isa_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // Bit 30 picks SUB and SRA in the ALU group
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [31:0] nop_instr = 32'h0000_0013; // ADDI x0, x0, 0

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } instr_u;

endpackage

/* hdl/pipe_ctrl_pkg.sv */
package pipe_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_A_RS1  = 2'd0,
        SRC_A_PC   = 2'd1,
        SRC_A_ZERO = 2'd2
    } src_a_sel_e;

    typedef enum logic {
        SRC_B_RS2 = 1'b0,
        SRC_B_IMM = 1'b1
    } src_b_sel_e;

    typedef enum logic [1:0] {
        WB_ALU       = 2'd0,
        WB_PC_PLUS_4 = 2'd1
    } wb_sel_e;

endpackage

/* hdl/instr_decoder.sv */
module instr_decoder
    import rv_isa_pkg::*, pipe_ctrl_pkg::*;
#(
    parameter int NUM_REGS = 32
)(
    input  logic        in_valid,
    input  logic [31:0] in_instr,
    output logic [4:0]  rs1,
    output logic [4:0]  rs2,
    output logic [4:0]  rd,
    output logic        uses_rs1,
    output logic        uses_rs2,
    output logic [31:0] imm,
    output alu_op_e     alu_op,
    output src_a_sel_e  src_a_sel,
    output src_b_sel_e  src_b_sel,
    output wb_sel_e     wb_sel,
    output logic        reg_write,
    output logic        branch,
    output logic        jump,
    output logic        jalr,
    output logic [2:0]  funct3
);

    instr_u word;
    logic   known;
    logic   writes;
    logic   is_branch;
    logic   is_jump;
    logic   is_jalr;
    logic   in_range;

    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        case (f3)
            F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR:     return ALU_XOR;
            F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
            F3_OR:      return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    assign word   = in_instr;
    assign rs1    = word.r.rs1;
    assign rs2    = word.r.rs2;
    assign rd     = word.r.rd;
    assign funct3 = word.r.funct3;

    always_comb begin
        imm       = '0;
        alu_op    = ALU_ADD; // Jumps, branches, LUI and AUIPC all add
        src_a_sel = SRC_A_RS1;
        src_b_sel = SRC_B_IMM;
        wb_sel    = WB_ALU;
        uses_rs1  = 1'b0;
        uses_rs2  = 1'b0;
        known     = 1'b1;
        writes    = 1'b1;
        is_branch = 1'b0;
        is_jump   = 1'b0;
        is_jalr   = 1'b0;
        case (word.r.opcode)
            OPC_OP: begin
                uses_rs1  = 1'b1;
                uses_rs2  = 1'b1;
                src_b_sel = SRC_B_RS2;
                alu_op    = alu_decode(funct3, word.r.funct7[5]);
            end
            OPC_OP_IMM: begin
                uses_rs1 = 1'b1;
                imm      = {{20{word.i.imm_11_0[11]}}, word.i.imm_11_0};
                alu_op   = alu_decode(funct3, word.r.funct7[5] && funct3 == F3_SRL_SRA);
            end
            OPC_LUI, OPC_AUIPC: begin
                imm       = {word.u.imm_31_12, 12'b0};
                src_a_sel = (word.r.opcode == OPC_LUI) ? SRC_A_ZERO : SRC_A_PC;
            end
            OPC_JAL: begin
                imm = {{12{word.j.imm_20}}, word.j.imm_19_12, word.j.imm_11,
                       word.j.imm_10_1, 1'b0};
                src_a_sel = SRC_A_PC;
                wb_sel    = WB_PC_PLUS_4;
                is_jump   = 1'b1;
            end
            OPC_JALR: begin
                uses_rs1 = 1'b1;
                imm      = {{20{word.i.imm_11_0[11]}}, word.i.imm_11_0};
                wb_sel   = WB_PC_PLUS_4;
                is_jump  = 1'b1;
                is_jalr  = 1'b1;
            end
            OPC_BRANCH: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                imm = {{20{word.b.imm_12}}, word.b.imm_11, word.b.imm_10_5,
                       word.b.imm_4_1, 1'b0};
                src_a_sel = SRC_A_PC; // ALU forms the target, compare is separate
                writes    = 1'b0;
                is_branch = 1'b1;
                known     = funct3[2:1] != 2'b01;
            end
            default: known = 1'b0;
        endcase

        in_range = !(uses_rs1 && rs1 >= NUM_REGS) && !(uses_rs2 && rs2 >= NUM_REGS)
                   && !(writes && rd >= NUM_REGS);
        reg_write = in_valid && known && in_range && writes;
        branch    = in_valid && known && in_range && is_branch;
        jump      = in_valid && known && in_range && is_jump;
        jalr      = jump && is_jalr;
    end

endmodule

/* hdl/register_file.sv */
module register_file #(
    parameter int NUM_REGS = 32
)(
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic        we,
    input  logic [4:0]  wr_addr,
    input  logic [31:0] wr_data,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data
);

    localparam int IDX_W = $clog2(NUM_REGS);

    logic [31:0] regs [NUM_REGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wr_addr != 5'd0 && wr_addr < NUM_REGS) begin
            regs[wr_addr[IDX_W-1:0]] <= wr_data;
        end
    end

    // Indices beyond the file read as zero like x0
    assign rs1_data = (rs1 != 5'd0 && rs1 < NUM_REGS) ? regs[rs1[IDX_W-1:0]] : '0;
    assign rs2_data = (rs2 != 5'd0 && rs2 < NUM_REGS) ? regs[rs2[IDX_W-1:0]] : '0;

    wr_addr_in_range: assert property (
        @(posedge clk) disable iff (reset) we |-> wr_addr < NUM_REGS
    ) else $error("Write to x%0d outside a %0d-entry register file", wr_addr, NUM_REGS);

endmodule

/* hdl/id_ex_register.sv */
module id_ex_register
    import rv_isa_pkg::*, pipe_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        bubble,
    input  logic        valid,
    input  logic [31:0] pc,
    input  logic        pred_taken,
    input  logic [31:0] instr,
    input  logic [4:0]  rd,
    input  logic [31:0] imm,
    input  alu_op_e     alu_op,
    input  src_a_sel_e  src_a_sel,
    input  src_b_sel_e  src_b_sel,
    input  wb_sel_e     wb_sel,
    input  logic        reg_write,
    input  logic        branch,
    input  logic        jump,
    input  logic        jalr,
    input  logic [2:0]  funct3,
    input  logic [31:0] rs1_data,
    input  logic [31:0] rs2_data,
    output logic        ex_valid,
    output logic [31:0] ex_pc,
    output logic        ex_pred_taken,
    output logic [31:0] ex_instr,
    output logic [4:0]  ex_rd,
    output logic [31:0] ex_imm,
    output alu_op_e     ex_alu_op,
    output src_a_sel_e  ex_src_a_sel,
    output src_b_sel_e  ex_src_b_sel,
    output wb_sel_e     ex_wb_sel,
    output logic        ex_reg_write,
    output logic        ex_branch,
    output logic        ex_jump,
    output logic        ex_jalr,
    output logic [2:0]  ex_funct3,
    output logic [31:0] ex_rs1_data,
    output logic [31:0] ex_rs2_data
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex_valid     <= 1'b0;
            ex_instr     <= nop_instr;
            ex_rd        <= '0;
            ex_reg_write <= 1'b0;
            ex_branch    <= 1'b0;
            ex_jump      <= 1'b0;
            ex_jalr      <= 1'b0;
        end else if (bubble) begin // A stall or flush turns the slot into a NOP
            ex_valid     <= 1'b0;
            ex_instr     <= nop_instr;
            ex_rd        <= '0;
            ex_reg_write <= 1'b0;
            ex_branch    <= 1'b0;
            ex_jump      <= 1'b0;
            ex_jalr      <= 1'b0;
        end else begin
            ex_valid     <= valid;
            ex_instr     <= instr;
            ex_rd        <= rd;
            ex_reg_write <= reg_write;
            ex_branch    <= branch;
            ex_jump      <= jump;
            ex_jalr      <= jalr;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc         <= pc;
        ex_pred_taken <= pred_taken;
        ex_imm        <= imm;
        ex_alu_op     <= alu_op;
        ex_src_a_sel  <= src_a_sel;
        ex_src_b_sel  <= src_b_sel;
        ex_wb_sel     <= wb_sel;
        ex_funct3     <= funct3;
        ex_rs1_data   <= rs1_data;
        ex_rs2_data   <= rs2_data;
    end

    bubble_never_writes: assert property (
        @(posedge clk) disable iff (reset) bubble |=> !ex_reg_write
    ) else $error("Bubble left a register write in EX");

endmodule

/* hdl/execute_unit.sv */
module execute_unit
    import rv_isa_pkg::*, pipe_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        ex_valid,
    input  logic [31:0] ex_pc,
    input  logic        ex_pred_taken,
    input  logic [31:0] ex_instr,
    input  logic [4:0]  ex_rd,
    input  logic [31:0] ex_imm,
    input  alu_op_e     ex_alu_op,
    input  src_a_sel_e  ex_src_a_sel,
    input  src_b_sel_e  ex_src_b_sel,
    input  wb_sel_e     ex_wb_sel,
    input  logic        ex_reg_write,
    input  logic        ex_branch,
    input  logic        ex_jump,
    input  logic        ex_jalr,
    input  logic [2:0]  ex_funct3,
    input  logic [31:0] ex_rs1_data,
    input  logic [31:0] ex_rs2_data,
    output logic        mispredict,
    output logic        wb_we,
    output logic [4:0]  wb_addr,
    output logic [31:0] wb_data,
    output logic        retire_valid,
    output logic [31:0] retire_pc,
    output logic [4:0]  retire_rd,
    output logic        retire_we,
    output logic [31:0] retire_data,
    output logic        redirect_valid,
    output logic [31:0] redirect_pc
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_result;
    logic [31:0] pc_plus_4;
    logic [31:0] target;
    logic        cond;

    always_comb begin
        case (ex_src_a_sel)
            SRC_A_RS1: op_a = ex_rs1_data;
            SRC_A_PC:  op_a = ex_pc;
            default:   op_a = '0;
        endcase
        op_b = (ex_src_b_sel == SRC_B_IMM) ? ex_imm : ex_rs2_data;

        case (ex_alu_op)
            ALU_ADD:  alu_result = op_a + op_b;
            ALU_SUB:  alu_result = op_a - op_b;
            ALU_SLL:  alu_result = op_a << op_b[4:0];
            ALU_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_result = {31'b0, op_a < op_b};
            ALU_XOR:  alu_result = op_a ^ op_b;
            ALU_SRL:  alu_result = op_a >> op_b[4:0];
            ALU_SRA:  alu_result = $unsigned($signed(op_a) >>> op_b[4:0]);
            ALU_OR:   alu_result = op_a | op_b;
            default:  alu_result = op_a & op_b;
        endcase

        case (ex_funct3)
            F3_BEQ:  cond = ex_rs1_data == ex_rs2_data;
            F3_BNE:  cond = ex_rs1_data != ex_rs2_data;
            F3_BLT:  cond = $signed(ex_rs1_data) < $signed(ex_rs2_data);
            F3_BGE:  cond = $signed(ex_rs1_data) >= $signed(ex_rs2_data);
            F3_BLTU: cond = ex_rs1_data < ex_rs2_data;
            F3_BGEU: cond = ex_rs1_data >= ex_rs2_data;
            default: cond = 1'b0;
        endcase
    end

    assign pc_plus_4  = ex_pc + 32'd4;
    assign target     = {alu_result[31:1], alu_result[0] & ~ex_jalr};
    assign mispredict = ex_jump || (ex_branch && cond != ex_pred_taken);

    assign wb_we   = ex_reg_write;
    assign wb_addr = ex_rd;
    assign wb_data = (ex_wb_sel == WB_PC_PLUS_4) ? pc_plus_4 : alu_result;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            retire_valid   <= 1'b0;
            retire_we      <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            retire_valid   <= ex_valid;
            retire_we      <= ex_reg_write;
            redirect_valid <= mispredict;
        end
    end

    always_ff @(posedge clk) begin
        retire_pc   <= ex_pc;
        retire_rd   <= ex_rd;
        retire_data <= wb_data;
        redirect_pc <= (ex_jump || (ex_branch && cond)) ? target : pc_plus_4;
    end

endmodule

/* hdl/hazard_unit.sv */
module hazard_unit (
    input  logic       clk,
    input  logic       reset,
    input  logic [4:0] rs1,
    input  logic [4:0] rs2,
    input  logic       uses_rs1,
    input  logic       uses_rs2,
    input  logic       in_valid,
    input  logic [4:0] ex_rd,
    input  logic       ex_reg_write,
    input  logic       mispredict,
    output logic       in_ready,
    output logic       bubble
);

    logic raw_hit;
    logic stall;

    // The register file is written at the end of EX, so one bubble is enough
    assign raw_hit = ex_reg_write && ex_rd != 5'd0
                     && ((uses_rs1 && rs1 == ex_rd) || (uses_rs2 && rs2 == ex_rd));

    assign stall    = in_valid && raw_hit && !mispredict; // Wrong-path slot is taken and dropped
    assign in_ready = !stall;
    assign bubble   = stall || mispredict;

    single_cycle_stall: assert property (
        @(posedge clk) disable iff (reset) !in_ready |=> in_ready
    ) else $error("Decode stalled twice on the same instruction");

endmodule

/* hdl/decode_execute_core.sv */
module decode_execute_core
    import pipe_ctrl_pkg::*;
#(
    parameter int NUM_REGS = 32
)(
    input  logic        clk,
    input  logic        reset,
    input  logic        in_valid,
    input  logic [31:0] in_instr,
    input  logic [31:0] in_pc,
    input  logic        in_pred_taken,
    output logic        in_ready,
    output logic        retire_valid,
    output logic [31:0] retire_pc,
    output logic [4:0]  retire_rd,
    output logic        retire_we,
    output logic [31:0] retire_data,
    output logic        redirect_valid,
    output logic [31:0] redirect_pc
);

    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic        uses_rs1;
    logic        uses_rs2;
    logic [31:0] imm;
    alu_op_e     alu_op;
    src_a_sel_e  src_a_sel;
    src_b_sel_e  src_b_sel;
    wb_sel_e     wb_sel;
    logic        reg_write;
    logic        branch;
    logic        jump;
    logic        jalr;
    logic [2:0]  funct3;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        bubble;
    logic        mispredict;

    logic        ex_valid;
    logic [31:0] ex_pc;
    logic        ex_pred_taken;
    logic [31:0] ex_instr;
    logic [4:0]  ex_rd;
    logic [31:0] ex_imm;
    alu_op_e     ex_alu_op;
    src_a_sel_e  ex_src_a_sel;
    src_b_sel_e  ex_src_b_sel;
    wb_sel_e     ex_wb_sel;
    logic        ex_reg_write;
    logic        ex_branch;
    logic        ex_jump;
    logic        ex_jalr;
    logic [2:0]  ex_funct3;
    logic [31:0] ex_rs1_data;
    logic [31:0] ex_rs2_data;

    logic        wb_we;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;

    instr_decoder #(.NUM_REGS(NUM_REGS)) u_decoder (
        .in_valid, .in_instr, .rs1, .rs2, .rd, .uses_rs1, .uses_rs2, .imm,
        .alu_op, .src_a_sel, .src_b_sel, .wb_sel, .reg_write, .branch, .jump,
        .jalr, .funct3
    );

    register_file #(.NUM_REGS(NUM_REGS)) u_regs (
        .clk, .reset, .rs1, .rs2, .we(wb_we), .wr_addr(wb_addr), .wr_data(wb_data),
        .rs1_data, .rs2_data
    );

    hazard_unit u_hazard (
        .clk, .reset, .rs1, .rs2, .uses_rs1, .uses_rs2, .in_valid, .ex_rd,
        .ex_reg_write, .mispredict, .in_ready, .bubble
    );

    id_ex_register u_id_ex (
        .clk, .reset, .bubble, .valid(in_valid), .pc(in_pc), .pred_taken(in_pred_taken),
        .instr(in_instr), .rd, .imm, .alu_op, .src_a_sel, .src_b_sel, .wb_sel,
        .reg_write, .branch, .jump, .jalr, .funct3, .rs1_data, .rs2_data,
        .ex_valid, .ex_pc, .ex_pred_taken, .ex_instr, .ex_rd, .ex_imm, .ex_alu_op,
        .ex_src_a_sel, .ex_src_b_sel, .ex_wb_sel, .ex_reg_write, .ex_branch,
        .ex_jump, .ex_jalr, .ex_funct3, .ex_rs1_data, .ex_rs2_data
    );

    execute_unit u_execute (
        .clk, .reset, .ex_valid, .ex_pc, .ex_pred_taken, .ex_instr, .ex_rd, .ex_imm,
        .ex_alu_op, .ex_src_a_sel, .ex_src_b_sel, .ex_wb_sel, .ex_reg_write,
        .ex_branch, .ex_jump, .ex_jalr, .ex_funct3, .ex_rs1_data, .ex_rs2_data,
        .mispredict, .wb_we, .wb_addr, .wb_data, .retire_valid, .retire_pc,
        .retire_rd, .retire_we, .retire_data, .redirect_valid, .redirect_pc
    );

endmodule

/* test/tb_decode_execute.sv */
module tb_decode_execute;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD  = 20;
    localparam int DRIVE_DELAY = 2;
    localparam int COLS        = 9;
    localparam int MAX_ROWS    = 64;

    // Column order of one pattern row
    localparam int C_INSTR    = 0;
    localparam int C_PC       = 1;
    localparam int C_PRED     = 2;
    localparam int C_RETIRE   = 3;
    localparam int C_RD       = 4;
    localparam int C_WE       = 5;
    localparam int C_DATA     = 6;
    localparam int C_REDIR    = 7;
    localparam int C_REDIR_PC = 8;

    logic        clk;
    logic        reset;
    logic        in_valid;
    logic [31:0] in_instr;
    logic [31:0] in_pc;
    logic        in_pred_taken;
    logic        in_ready;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic [4:0]  retire_rd;
    logic        retire_we;
    logic [31:0] retire_data;
    logic        redirect_valid;
    logic [31:0] redirect_pc;

    logic [31:0] pat_mem [0:MAX_ROWS*COLS];
    int          num_rows;
    int          exp_q [$];
    int          pass_count;
    int          fail_count;
    int          test_errs;
    int          stall_count;

    decode_execute_core #(.NUM_REGS(32)) u_dut (
        .clk, .reset, .in_valid, .in_instr, .in_pc, .in_pred_taken, .in_ready,
        .retire_valid, .retire_pc, .retire_rd, .retire_we, .retire_data,
        .redirect_valid, .redirect_pc
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] pattern_field(input int row, input int col);
        return pat_mem[1 + row * COLS + col]; // Word 0 holds the row count
    endfunction

    task automatic compare_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error: %s expected 0x%h, got 0x%h", name, expected, actual);
            test_errs++;
        end
    endtask

    task automatic check_retire(input logic [31:0] exp_pc, input logic [4:0] exp_rd,
                                input logic exp_we, input logic [31:0] exp_data);
        if (retire_pc !== exp_pc) begin
            $display("** Error: retire_pc expected 0x%h, got 0x%h", exp_pc, retire_pc);
            test_errs++;
        end
        compare_flag("retire_we", exp_we, retire_we);
        if (exp_we) begin // rd and data only mean something for a write
            if (retire_rd !== exp_rd) begin
                $display("** Error: retire_rd expected 0x%h, got 0x%h", exp_rd, retire_rd);
                test_errs++;
            end
            if (retire_data !== exp_data) begin
                $display("** Error: retire_data expected 0x%h, got 0x%h", exp_data, retire_data);
                test_errs++;
            end
        end
    endtask

    task automatic check_redirect(input logic exp_valid, input logic [31:0] exp_pc);
        compare_flag("redirect_valid", exp_valid, redirect_valid);
        if (exp_valid && redirect_pc !== exp_pc) begin
            $display("** Error: redirect_pc expected 0x%h, got 0x%h", exp_pc, redirect_pc);
            test_errs++;
        end
    endtask

    task automatic report_test(input string name);
        if (test_errs == 0) begin
            pass_count++;
            $display("PASS  %s", name);
        end else begin
            fail_count++;
            $display("FAIL  %s (%0d mismatches)", name, test_errs);
        end
    endtask

    initial begin : monitor
        int          row;
        logic [31:0] rd_word;
        @(negedge reset);
        forever begin
            @(negedge clk);
            if (retire_valid === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("Retirement at pc 0x%h matches no accepted row", retire_pc);
                    fail_count++;
                end else begin
                    row       = exp_q.pop_front();
                    rd_word   = pattern_field(row, C_RD);
                    test_errs = 0;
                    check_retire(pattern_field(row, C_PC), rd_word[4:0],
                                 pattern_field(row, C_WE) != 0, pattern_field(row, C_DATA));
                    check_redirect(pattern_field(row, C_REDIR) != 0,
                                   pattern_field(row, C_REDIR_PC));
                    report_test($sformatf("row %0d at pc 0x%h", row, pattern_field(row, C_PC)));
                end
            end else if (redirect_valid === 1'b1) begin
                $display("Redirect to 0x%h arrived without a retirement", redirect_pc);
                fail_count++;
            end
        end
    end

    initial begin : watchdog
        wait (num_rows > 0);
        repeat (num_rows * 4 + 20) @(posedge clk);
        $display("Timeout after %0d cycles, the stream never drained", num_rows * 4 + 20);
        $display("test failed");
        $finish;
    end

    initial begin : main
        int r;
        int waits;
        bit accepted;
        reset         = 1'b1;
        in_valid      = 1'b0;
        in_instr      = '0;
        in_pc         = '0;
        in_pred_taken = 1'b0;
        pass_count    = 0;
        fail_count    = 0;
        test_errs     = 0;
        stall_count   = 0;
        $readmemh("test/exec_patterns.txt", pat_mem);
        num_rows = pat_mem[0];
        if (num_rows < 1 || num_rows > MAX_ROWS) begin
            $display("Pattern file gives %0d rows, which cannot be run", num_rows);
            $display("test failed");
            $finish;
        end else begin
            repeat (2) @(posedge clk);
            #DRIVE_DELAY reset = 1'b0;

            test_errs = 0;
            repeat (2) begin
                @(negedge clk);
                compare_flag("retire_valid", 1'b0, retire_valid);
                compare_flag("retire_we", 1'b0, retire_we);
                compare_flag("redirect_valid", 1'b0, redirect_valid);
            end
            report_test("reset state");
            @(posedge clk);
            #DRIVE_DELAY;

            for (r = 0; r < num_rows; r++) begin
                in_valid      = 1'b1;
                in_instr      = pattern_field(r, C_INSTR);
                in_pc         = pattern_field(r, C_PC);
                in_pred_taken = pattern_field(r, C_PRED) != 0;
                waits = 0;
                do begin
                    @(negedge clk);
                    accepted = in_ready;
                    if (!accepted) begin
                        waits++;
                    end
                    @(posedge clk);
                    #DRIVE_DELAY;
                end while (!accepted);
                if (r == 0 && waits != 0) begin
                    $display("in_ready was low for the first row after reset");
                    fail_count++;
                end
                if (waits > 1) begin
                    $display("Row %0d was held off for %0d cycles instead of one", r, waits);
                    fail_count++;
                end
                stall_count += waits;
                if (pattern_field(r, C_RETIRE) != 0) begin
                    exp_q.push_back(r);
                end
            end
            in_valid = 1'b0;

            while (exp_q.size() != 0) begin
                @(posedge clk);
            end
            repeat (4) @(posedge clk); // Leaves room for a stray retirement to show up

            test_errs = 0;
            if (stall_count == 0) begin
                $display("in_ready never dropped, so no read-after-write stall was seen");
                test_errs++;
            end
            report_test($sformatf("hazard stalls (%0d cycles)", stall_count));

            $display("Tests run: %0d, passed: %0d, failed: %0d",
                     pass_count + fail_count, pass_count, fail_count);
            if (fail_count == 0 && pass_count > 0) begin
                $display("test passed");
            end else begin
                $display("test failed");
            end
            $finish;
        end
    end

endmodule

/* test/exec_patterns.txt */
// Row count first, then one row per instruction, all hex:
// instr pc pred_taken expect_retire rd we data redirect redirect_pc
1a
00500093 00000100 0 1 01 1 00000005 0 00000000
ffd00113 00000104 0 1 02 1 fffffffd 0 00000000
002081b3 00000108 0 1 03 1 00000002 0 00000000
40208233 0000010c 0 1 04 1 00000008 0 00000000
001122b3 00000110 0 1 05 1 00000001 0 00000000
00113333 00000114 0 1 06 1 00000000 0 00000000
40115393 00000118 0 1 07 1 fffffffe 0 00000000
0f03c413 0000011c 0 1 08 1 ffffff0e 0 00000000
123454b7 00000120 0 1 09 1 12345000 0 00000000
00001517 00000124 0 1 0a 1 00001124 0 00000000
00700013 00000128 0 1 00 1 00000007 0 00000000
000005b3 0000012c 0 1 0b 1 00000000 0 00000000
00108463 00000130 1 1 00 0 00000000 0 00000000
00409863 00000138 0 1 00 0 00000000 1 00000148
05500613 0000013c 0 0 0c 1 00000055 0 00000000
00115463 00000148 1 1 00 0 00000000 1 0000014c
06600613 00000150 0 0 0c 1 00000066 0 00000000
fe20ece3 0000014c 1 1 00 0 00000000 0 00000000
000606b3 00000144 0 1 0d 1 00000000 0 00000000
020000ef 00000148 0 1 01 1 0000014c 1 00000168
07700093 0000014c 0 0 01 1 00000077 0 00000000
005202e7 00000168 0 1 05 1 0000016c 1 0000000c
00100313 0000016c 0 0 06 1 00000001 0 00000000
0000a703 0000000c 0 1 00 0 00000000 0 00000000
000707b3 00000010 0 1 0f 1 00000000 0 00000000
00978813 00000014 0 1 10 1 00000009 0 00000000

/* flist.f */
hdl/rv_isa_pkg.sv
hdl/pipe_ctrl_pkg.sv
hdl/instr_decoder.sv
hdl/register_file.sv
hdl/id_ex_register.sv
hdl/execute_unit.sv
hdl/hazard_unit.sv
hdl/decode_execute_core.sv
test/tb_decode_execute.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_decode_execute
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FLIST     ?= flist.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SIM  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell cat $(FLIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP BUILD_DIR LOG FLIST VFLAGS"

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

test: $(SIM)
	$(SIM) | tee $(LOG)
	@grep -qx "test passed" $(LOG) || { echo "Simulation FAILED, see $(LOG)"; exit 1; }
	@echo "Simulation PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
